// ==== memStage_vectors.txt ====
# pc instr aluOut storeData load store wbSel dst regWr mtc0 br exc irq flush code val
# val is the writeback result, or the epc expected after an exception
BFC00000 00000000 80000010 11223344 0 3 1 00 0 0 0 00 00 0 00 80000010
BFC00004 00000000 80000012 0000A5B6 0 2 1 00 0 0 0 00 00 0 00 80000012
BFC00008 00000000 A0000011 000000C7 0 1 1 00 0 0 0 00 00 0 00 A0000011
BFC0000C 8C030000 80000010 00000000 5 0 2 03 1 0 0 00 00 0 00 A5B6C744
BFC00010 8C030000 80000013 00000000 1 0 2 03 1 0 0 00 00 0 00 FFFFFFA5
BFC00014 8C030000 80000013 00000000 2 0 2 03 1 0 0 00 00 0 00 000000A5
BFC00018 8C030000 80000012 00000000 3 0 2 03 1 0 0 00 00 0 00 FFFFA5B6
BFC0001C 8C030000 80000010 00000000 4 0 2 03 1 0 0 00 00 0 00 0000C744
BFC00020 8C030000 80000012 00000000 5 0 2 03 1 0 0 00 00 1 04 BFC00020
BFC00024 40816000 00000000 0000FF01 0 0 1 00 0 1 0 00 00 0 00 00000000
BFC00028 40026000 00000000 00000000 0 0 3 02 1 0 0 00 00 0 00 0000FF01
BFC0002C 00000000 00001000 12345678 0 3 1 00 0 0 0 00 00 1 05 BFC0002C
BFC00030 40816000 00000000 0000FF01 0 0 1 00 0 1 0 00 00 0 00 00000000
BFC00034 8C030000 80000400 00000000 5 0 2 03 1 0 0 00 00 1 07 BFC00034
BFC00038 40816000 00000000 0000FF01 0 0 1 00 0 1 0 00 00 0 00 00000000
BFC0003C 00000000 00000777 00000000 0 0 1 04 1 0 0 00 01 1 00 BFC0003C
BFC00040 00000000 00000888 00000000 0 0 1 04 1 0 0 00 01 0 00 00000888
BFC00044 40816000 00000000 0000FB01 0 0 1 00 0 1 0 00 01 0 00 00000000
BFC00048 00000000 00000999 00000000 0 0 1 04 1 0 0 00 01 0 00 00000999
BFC0004C 40815800 00000000 12345678 0 0 1 00 0 1 0 00 00 0 00 00000000
BFC00050 40025800 00000000 00000000 0 0 3 02 1 0 0 00 00 0 00 12345678
BFC00054 00000000 00000000 00000000 0 0 0 1F 1 0 1 00 00 0 00 BFC0005C
BFC00058 00000000 00000000 00000000 0 0 1 00 0 0 0 02 00 1 08 BFC00054
BFC0005C 40026800 00000000 00000000 0 0 3 02 1 0 0 00 00 0 00 80000020
BFC00060 40816000 00000000 0000FB01 0 0 1 00 0 1 0 00 00 0 00 00000000
BFC00064 00000000 00000000 00000000 0 0 1 04 1 0 0 08 00 1 0A BFC00064
BFC00068 40816000 00000000 0000FB01 0 0 1 00 0 1 0 00 00 0 00 00000000
BFC0006C 00000000 00000000 00000000 0 0 1 04 1 0 0 04 00 1 0C BFC0006C
BFC00070 00000000 00000000 00000000 0 0 1 04 1 0 0 01 00 1 09 BFC0006C
BFC00074 00000000 DEADBEEF 00000000 0 0 1 05 1 0 0 00 00 0 00 DEADBEEF

// ==== memStage.f ====
+incdir+.
pipePkg.sv
cp0Pkg.sv
memPipeReg.sv
apbDataPort.sv
exceptionUnit.sv
cp0Regs.sv
memStage.sv
memStageTb.sv

// ==== runSim.sh ====
#!/bin/bash
# build and run the memory stage testbench, pass only if the log says so
rm -f sim.log
(verilator --binary -Wno-fatal --top-module memStageTb -f memStage.f -o memStageSim \
    && ./obj_dir/memStageSim) > sim.log 2>&1 || echo "build or simulation returned an error"
grep -qF "*** TEST PASSED ***" sim.log && echo "PASS" && exit 0 || { echo "FAIL, see sim.log"; exit 1; }

// ==== memStageTb.sv ====
`include "memStage_defs.svh"

module memStageTb;
    timeunit 1ns;
    timeprecision 1ps;

    import pipePkg::*;
    import cp0Pkg::*;

    localparam logic [31:0] ERR_LIMIT = 32'h0000_0400;   // slave errors from here up
    localparam int          TIMEOUT   = 50;

    logic        clk;
    logic        arstN;
    exeMemBundle exeIn;
    logic        exeValid;
    logic        memReady;
    logic [5:0]  interrupt;
    apbRequest   apbOut;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    memWbBundle  wbOut;
    logic        excFlush;
    logic [31:0] excVector;
    logic [31:0] epc;

    logic [31:0] mem [0:255];
    integer      seed = 32'h70ad7c00;
    int          waitLeft;
    logic        apbSeen;
    logic        bevModel;     // tracks Status.BEV from the vectors

    // one vector line
    logic [31:0] vPc, vInstr, vAlu, vSd, vVal;
    logic [2:0]  vLoad;
    logic [1:0]  vStore, vWbSel;
    logic [4:0]  vDst, vExc, vCode;
    logic        vRegWr, vMtc0, vBr, vFlush;
    logic [5:0]  vIrq;

    memStage DUT (
        .clk       (clk),
        .arstN     (arstN),
        .exeIn     (exeIn),
        .exeValid  (exeValid),
        .memReady  (memReady),
        .interrupt (interrupt),
        .apbOut    (apbOut),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .wbOut     (wbOut),
        .excFlush  (excFlush),
        .excVector (excVector),
        .epc       (epc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abortRun(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // byte lanes a store must enable, one for each byte it writes
    function automatic logic [3:0] strobeFor(input storeKind kind, input logic [1:0] lowAddr);
        int         size;
        logic [3:0] lanes;
        case (kind)
            ST_SB:   size = 1;
            ST_SH:   size = 2;
            ST_SW:   size = 4;
            default: size = 0;
        endcase
        lanes = '0;
        for (int b = 0; b < 4; b++) begin
            if (b >= lowAddr && b < lowAddr + size) lanes[b] = 1'b1;
        end
        return lanes;
    endfunction

    // APB slave with random wait states
    always @(negedge clk) begin
        if (apbOut.psel && !apbOut.penable) begin
            apbSeen  = 1'b1;
            waitLeft = $unsigned($random(seed)) % 4;
            pready   = 1'b0;
            if (apbOut.pwrite) begin
                assert (apbOut.pstrb == strobeFor(storeKind'(vStore), vAlu[1:0])) else
                    abortRun($sformatf("Error: apbOut.pstrb is %h, expected %h", apbOut.pstrb,
                                       strobeFor(storeKind'(vStore), vAlu[1:0])));
            end
        end else if (apbOut.psel && apbOut.penable) begin
            if (waitLeft == 0) begin
                pready  = 1'b1;
                pslverr = apbOut.paddr >= ERR_LIMIT;
                prdata  = mem[apbOut.paddr[9:2]];
                if (apbOut.pwrite && !pslverr) begin
                    for (int b = 0; b < 4; b++) begin
                        if (apbOut.pstrb[b]) begin
                            mem[apbOut.paddr[9:2]][b*8 +: 8] = apbOut.pwdata[b*8 +: 8];
                        end
                    end
                end
            end else begin
                waitLeft = waitLeft - 1;
            end
        end else begin
            pready  = 1'b0;
            pslverr = 1'b0;
        end
    end

    task automatic applyVector();
        int          cnt;
        logic [31:0] expVector;
        cnt = 0;
        while (!memReady) begin
            cnt++;
            if (cnt > TIMEOUT) abortRun("timeout while waiting for memReady");
            @(negedge clk);
        end
        exeIn                = '0;
        exeIn.pc             = vPc;
        exeIn.instr          = vInstr;
        exeIn.aluOut         = vAlu;
        exeIn.storeData      = vSd;
        exeIn.load           = loadKind'(vLoad);
        exeIn.store          = storeKind'(vStore);
        exeIn.wbSel          = wbSelect'(vWbSel);
        exeIn.dst            = (vLoad != 3'd0) ? ~vDst : vDst;   // a load must write rt instead
        exeIn.regWr          = vRegWr;
        exeIn.isMtc0         = vMtc0;
        exeIn.isBranchOrJump = vBr;
        exeIn.exc            = vExc;
        interrupt            = vIrq;
        exeValid             = 1'b1;
        apbSeen              = 1'b0;
        @(posedge clk);      // stage is empty, so the bundle is taken here
        @(negedge clk);
        exeValid = 1'b0;
        cnt = 0;
        @(posedge clk);      // outputs still hold their settled pre-edge values
        while (!wbOut.valid) begin
            cnt++;
            if (cnt > TIMEOUT) abortRun("timeout while waiting for a writeback");
            @(posedge clk);
        end
        expVector = bevModel ? `EXC_VECTOR_BOOT : `EXC_VECTOR_NORMAL;
        assert (wbOut.pc == vPc) else
            abortRun($sformatf("Error: wbOut.pc is %h, expected %h", wbOut.pc, vPc));
        assert (excFlush == vFlush) else
            abortRun($sformatf("Error: excFlush is %h, expected %h at pc %h",
                               excFlush, vFlush, vPc));
        if (vFlush) begin
            assert (wbOut.regWr == 1'b0) else
                abortRun($sformatf("Error: wbOut.regWr is %h, expected 0", wbOut.regWr));
            assert (DUT.excRep.code == vCode) else
                abortRun($sformatf("Error: excRep.code is %h, expected %h",
                                   DUT.excRep.code, vCode));
            assert (excVector == expVector) else
                abortRun($sformatf("Error: excVector is %h, expected %h",
                                   excVector, expVector));
            if (vCode == 5'h04 || vCode == 5'h05) begin
                assert (!apbSeen) else
                    abortRun("an address error still started an APB transfer");
            end
        end else begin
            assert (wbOut.regWr == vRegWr) else
                abortRun($sformatf("Error: wbOut.regWr is %h, expected %h",
                                   wbOut.regWr, vRegWr));
            assert (wbOut.dst == vDst) else
                abortRun($sformatf("Error: wbOut.dst is %h, expected %h", wbOut.dst, vDst));
            assert (wbOut.result == vVal) else
                abortRun($sformatf("Error: wbOut.result is %h, expected %h at pc %h",
                                   wbOut.result, vVal, vPc));
            if (vMtc0 && vInstr[15:11] == `CP0_REG_STATUS) bevModel = vSd[22];
        end
        @(negedge clk);      // commit edge has passed
        if (vFlush) begin
            assert (epc == vVal) else
                abortRun($sformatf("Error: epc is %h, expected %h", epc, vVal));
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        arstN     = 1'b0;
        exeIn     = '0;
        exeValid  = 1'b0;
        interrupt = '0;
        prdata    = '0;
        pready    = 1'b0;
        pslverr   = 1'b0;
        bevModel  = 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5A5A_0000 ^ (i * 32'h0001_0003);
        end
        fd = $fopen("memStage_vectors.txt", "r");
        if (fd == 0) abortRun("the vector file could not be opened");
        repeat (4) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;   // header or blank
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        vPc, vInstr, vAlu, vSd, vLoad, vStore, vWbSel, vDst,
                        vRegWr, vMtc0, vBr, vExc, vIrq, vFlush, vCode, vVal);
            if (n != 16) abortRun("a vector line has the wrong number of columns");
            applyVector();
        end
        $fclose(fd);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== memStage.sv ====
module memStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  pipePkg::exeMemBundle  exeIn,
    input  logic                  exeValid,
    output logic                  memReady,
    input  logic [5:0]            interrupt,
    output pipePkg::apbRequest    apbOut,
    input  logic [31:0]           prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    output pipePkg::memWbBundle   wbOut,
    output logic                  excFlush,
    output logic [31:0]           excVector,
    output logic [31:0]           epc
);
    import pipePkg::*;
    import cp0Pkg::*;

    exeMemBundle memCur;
    logic        curValid;
    logic        inDelaySlot;
    logic [31:0] loadData;
    logic        accessDone;
    logic        busy;
    logic        dataErrValid;
    excCode      dataErrCode;
    excReport    excRep;
    statusFields status;
    logic        intPending;
    logic [31:0] cp0RdData;
    logic        isMemOp;
    logic        complete;
    logic [31:0] result;

    assign isMemOp  = (memCur.load != LD_NONE) || (memCur.store != ST_NONE);
    assign complete = curValid && (!isMemOp || accessDone);
    assign memReady = !busy;    // low only while a bus access is outstanding

    memPipeReg uPipeReg (
        .clk         (clk),
        .arstN       (arstN),
        .exeIn       (exeIn),
        .exeValid    (exeValid),
        .advance     (complete),
        .memCur      (memCur),
        .curValid    (curValid),
        .inDelaySlot (inDelaySlot)
    );

    apbDataPort uDataPort (
        .clk          (clk),
        .arstN        (arstN),
        .memCur       (memCur),
        .curValid     (curValid),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .apbOut       (apbOut),
        .loadData     (loadData),
        .accessDone   (accessDone),
        .busy         (busy),
        .dataErrValid (dataErrValid),
        .dataErrCode  (dataErrCode)
    );

    exceptionUnit uException (
        .memCur       (memCur),
        .curValid     (curValid),
        .complete     (complete),
        .inDelaySlot  (inDelaySlot),
        .dataErrValid (dataErrValid),
        .dataErrCode  (dataErrCode),
        .intPending   (intPending),
        .status       (status),
        .excRep       (excRep),
        .excFlush     (excFlush),
        .excVector    (excVector)
    );

    cp0Regs uCp0 (
        .clk        (clk),
        .arstN      (arstN),
        .interrupt  (interrupt),
        .memCur     (memCur),
        .complete   (complete),
        .excRep     (excRep),
        .rdData     (cp0RdData),
        .status     (status),
        .intPending (intPending),
        .epc        (epc)
    );

    always_comb begin
        case (memCur.wbSel)
            WB_LINK: result = memCur.pc + 32'd8;    // skip the delay slot
            WB_ALU:  result = memCur.aluOut;
            WB_LOAD: result = loadData;
            default: result = cp0RdData;
        endcase
    end

    always_comb begin
        wbOut.valid  = complete;
        wbOut.pc     = memCur.pc;
        wbOut.dst    = memCur.dst;
        wbOut.regWr  = memCur.regWr && !excRep.taken;
        wbOut.result = result;
    end

endmodule

// ==== cp0Regs.sv ====
`include "memStage_defs.svh"

module cp0Regs (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic [5:0]            interrupt,
    input  pipePkg::exeMemBundle  memCur,
    input  logic                  complete,
    input  cp0Pkg::excReport      excRep,
    output logic [31:0]           rdData,
    output cp0Pkg::statusFields   status,
    output logic                  intPending,
    output logic [31:0]           epc
);
    import cp0Pkg::*;

    causeFields  cause;
    statusFields wrStatus;
    causeFields  wrCause;
    logic [31:0] badVaddr;
    logic [31:0] count;
    logic [31:0] compare;
    logic [31:0] countNext;
    logic [31:0] wrData;
    logic [4:0]  regNum;
    logic        selZero;
    logic        mtc0Wr;

    assign regNum    = memCur.instr.cop0.rd;
    assign selZero   = memCur.instr.cop0.sel == 3'd0;
    assign wrData    = memCur.storeData;          // rt value
    assign wrStatus  = wrData;
    assign wrCause   = wrData;
    assign mtc0Wr    = complete && memCur.isMtc0 && selZero && !excRep.taken;
    assign countNext = count + 32'd1;

    assign intPending = |(cause.ip & status.im);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            status   <= `STATUS_RESET;
            cause    <= '0;
            epc      <= '0;
            badVaddr <= '0;
            count    <= '0;
            compare  <= '0;
        end else begin
            count         <= countNext;
            cause.ip[7:2] <= {interrupt[5] | cause.ti, interrupt[4:0]};   // timer shares ip7
            if (countNext == compare) begin
                cause.ti <= 1'b1;
            end
            if (excRep.taken) begin
                status.exl <= 1'b1;
                cause.code <= excRep.code;
                if (excRep.updateEpc) begin
                    epc      <= excRep.epcValue;
                    cause.bd <= excRep.inDelaySlot;
                end
                if (excRep.code inside {EXC_ADEL, EXC_ADES}) begin
                    badVaddr <= excRep.badVaddr;
                end
            end else if (mtc0Wr) begin
                case (regNum)
                    `CP0_REG_STATUS: begin
                        status.bev <= wrStatus.bev;
                        status.im  <= wrStatus.im;
                        status.exl <= wrStatus.exl;
                        status.ie  <= wrStatus.ie;
                    end
                    `CP0_REG_CAUSE:   cause.ip[1:0] <= wrCause.ip[1:0];   // soft ints only
                    `CP0_REG_EPC:     epc <= wrData;
                    `CP0_REG_COUNT:   count <= wrData;
                    `CP0_REG_COMPARE: begin
                        compare  <= wrData;
                        cause.ti <= 1'b0;    // acknowledges the timer
                    end
                    default: ;
                endcase
            end
        end
    end

    // mfc0 read port
    always_comb begin
        rdData = '0;
        if (selZero) begin
            case (regNum)
                `CP0_REG_STATUS:   rdData = status;
                `CP0_REG_CAUSE:    rdData = cause;
                `CP0_REG_EPC:      rdData = epc;
                `CP0_REG_BADVADDR: rdData = badVaddr;
                `CP0_REG_COUNT:    rdData = count;
                `CP0_REG_COMPARE:  rdData = compare;
                default:           rdData = '0;
            endcase
        end
    end

endmodule

// ==== exceptionUnit.sv ====
`include "memStage_defs.svh"

module exceptionUnit (
    input  pipePkg::exeMemBundle  memCur,
    input  logic                  curValid,
    input  logic                  complete,
    input  logic                  inDelaySlot,
    input  logic                  dataErrValid,
    input  cp0Pkg::excCode        dataErrCode,
    input  logic                  intPending,
    input  cp0Pkg::statusFields   status,
    output cp0Pkg::excReport      excRep,
    output logic                  excFlush,
    output logic [31:0]           excVector
);
    import cp0Pkg::*;

    logic   intTaken;
    logic   hit;
    logic   fromFetch;
    excCode code;

    assign intTaken = intPending && status.ie && !status.exl;

    // fixed priority, interrupt first and data error last
    always_comb begin
        hit       = 1'b1;
        fromFetch = 1'b0;
        code      = EXC_INT;
        if (intTaken) begin
            code = EXC_INT;
        end else if (memCur.exc.fetchAddrErr) begin
            code      = EXC_ADEL;
            fromFetch = 1'b1;
        end else if (memCur.exc.reservedInstr) begin
            code = EXC_RI;
        end else if (memCur.exc.overflow) begin
            code = EXC_OV;
        end else if (memCur.exc.syscall) begin
            code = EXC_SYS;
        end else if (memCur.exc.breakpoint) begin
            code = EXC_BP;
        end else if (dataErrValid) begin
            code = dataErrCode;
        end else begin
            hit = 1'b0;
        end
    end

    always_comb begin
        excRep.taken       = curValid && complete && hit;
        excRep.code        = code;
        excRep.inDelaySlot = inDelaySlot;
        excRep.updateEpc   = !status.exl;    // nested, keep the first EPC
        excRep.epcValue    = inDelaySlot ? memCur.pc - 32'd4 : memCur.pc;
        excRep.badVaddr    = fromFetch ? memCur.pc : memCur.aluOut;
    end

    assign excFlush  = excRep.taken;
    assign excVector = status.bev ? `EXC_VECTOR_BOOT : `EXC_VECTOR_NORMAL;

endmodule

// ==== apbDataPort.sv ====
`include "memStage_defs.svh"

module apbDataPort (
    input  logic                  clk,
    input  logic                  arstN,
    input  pipePkg::exeMemBundle  memCur,
    input  logic                  curValid,
    input  logic [31:0]           prdata,
    input  logic                  pready,
    input  logic                  pslverr,
    output pipePkg::apbRequest    apbOut,
    output logic [31:0]           loadData,
    output logic                  accessDone,
    output logic                  busy,
    output logic                  dataErrValid,
    output cp0Pkg::excCode        dataErrCode
);
    import pipePkg::*;
    import cp0Pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} apbPhase;

    apbPhase     state;
    apbPhase     phase;
    logic [31:0] vaddr;
    logic        isLoad;
    logic        isStore;
    logic        inSeg;
    logic        misaligned;
    logic        addrErr;
    logic        request;
    logic        busEnd;
    logic [31:0] shifted;

    assign vaddr   = memCur.aluOut;
    assign isLoad  = memCur.load != LD_NONE;
    assign isStore = memCur.store != ST_NONE;

    // kseg0 or kseg1, nothing mapped
    assign inSeg = (vaddr >= `KSEG0_BASE && vaddr < `KSEG1_BASE) ||
                   (vaddr >= `KSEG1_BASE && vaddr < `KSEG_TOP);

    always_comb begin
        misaligned = 1'b0;
        if (memCur.load inside {LD_LH, LD_LHU} || memCur.store == ST_SH) begin
            misaligned = vaddr[0];
        end else if (memCur.load == LD_LW || memCur.store == ST_SW) begin
            misaligned = |vaddr[1:0];
        end
    end

    assign addrErr = curValid && (isLoad || isStore) && (!inSeg || misaligned);
    // an instruction already faulting upstream never reaches the bus
    assign request = curValid && (isLoad || isStore) && !addrErr && !(|memCur.exc);

    // setup is issued in the first cycle the request is seen
    assign phase  = (state == IDLE && request) ? SETUP : state;
    assign busEnd = (phase == ACCESS) && pready;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            case (phase)
                SETUP:   state <= ACCESS;
                ACCESS:  state <= pready ? IDLE : ACCESS;
                default: state <= IDLE;
            endcase
        end
    end

    // memory op without a bus transfer ends at once
    assign accessDone   = busEnd || (curValid && (isLoad || isStore) && !request);
    assign busy         = (phase == SETUP) || (phase == ACCESS && !pready);
    assign dataErrValid = addrErr || (busEnd && pslverr);
    assign dataErrCode  = addrErr ? (isLoad ? EXC_ADEL : EXC_ADES) : EXC_DBE;

    always_comb begin
        apbOut.paddr   = {3'b000, vaddr[28:0]};   // strip segment bits
        apbOut.psel    = phase != IDLE;
        apbOut.penable = phase == ACCESS;
        apbOut.pwrite  = isStore;
        case (memCur.store)
            ST_SB: begin
                apbOut.pstrb  = 4'b0001 << vaddr[1:0];
                apbOut.pwdata = {4{memCur.storeData[7:0]}};
            end
            ST_SH: begin
                apbOut.pstrb  = vaddr[1] ? 4'b1100 : 4'b0011;
                apbOut.pwdata = {2{memCur.storeData[15:0]}};
            end
            ST_SW: begin
                apbOut.pstrb  = 4'b1111;
                apbOut.pwdata = memCur.storeData;
            end
            default: begin
                apbOut.pstrb  = 4'b0000;         // reads carry no strobes
                apbOut.pwdata = memCur.storeData;
            end
        endcase
    end

    // move the addressed lane down to bit 0
    assign shifted = prdata >> {vaddr[1:0], 3'b000};

    always_comb begin
        case (memCur.load)
            LD_LB:   loadData = {{24{shifted[7]}}, shifted[7:0]};
            LD_LBU:  loadData = {24'b0, shifted[7:0]};
            LD_LH:   loadData = {{16{shifted[15]}}, shifted[15:0]};
            LD_LHU:  loadData = {16'b0, shifted[15:0]};
            default: loadData = prdata;
        endcase
    end

endmodule

// ==== memPipeReg.sv ====
module memPipeReg (
    input  logic                  clk,
    input  logic                  arstN,
    input  pipePkg::exeMemBundle  exeIn,
    input  logic                  exeValid,
    input  logic                  advance,
    output pipePkg::exeMemBundle  memCur,
    output logic                  curValid,
    output logic                  inDelaySlot
);
    import pipePkg::*;

    exeMemBundle nextBundle;
    logic        loadEn;
    logic        take;
    logic        prevBranch;    // last accepted bundle was a branch or jump

    // empty, or the current one finishes this cycle
    assign loadEn = !curValid || advance;
    assign take   = loadEn && exeValid;

    // loads always write rt
    always_comb begin
        nextBundle = exeIn;
        if (exeIn.load != LD_NONE) begin
            nextBundle.dst = exeIn.instr.iType.rt;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            curValid    <= 1'b0;
            inDelaySlot <= 1'b0;
            prevBranch  <= 1'b0;
        end else begin
            if (loadEn) begin
                curValid <= exeValid;    // drops when nothing follows
            end
            if (take) begin
                inDelaySlot <= prevBranch;
                prevBranch  <= exeIn.isBranchOrJump;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            memCur <= nextBundle;
        end
    end

endmodule

// ==== cp0Pkg.sv ====
package cp0Pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_DBE  = 5'h07,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a,
        EXC_OV   = 5'h0c
    } excCode;

    typedef struct packed {
        logic [8:0] rsvd31to23;
        logic       bev;           // bit 22
        logic [5:0] rsvd21to16;
        logic [7:0] im;
        logic [5:0] rsvd7to2;
        logic       exl;
        logic       ie;
    } statusFields;

    typedef struct packed {
        logic        bd;
        logic        ti;           // timer hit, folded into ip[7]
        logic [13:0] rsvd29to16;
        logic [7:0]  ip;
        logic        rsvd7;
        excCode      code;
        logic [1:0]  rsvd1to0;
    } causeFields;

    typedef struct packed {
        logic        taken;
        excCode      code;
        logic        inDelaySlot;
        logic        updateEpc;    // low when EXL was already set
        logic [31:0] epcValue;
        logic [31:0] badVaddr;
    } excReport;

endpackage

// ==== pipePkg.sv ====
package pipePkg;

    // I-type view, used by loads and stores
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iTypeView;

    // COP0 view for mfc0/mtc0
    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  copOp;     // MF or MT
        logic [4:0]  rt;
        logic [4:0]  rd;        // cp0 register number
        logic [7:0]  zero;
        logic [2:0]  sel;
    } cop0View;

    typedef union packed {
        iTypeView iType;
        cop0View  cop0;
    } instrWord;

    typedef enum logic [2:0] {LD_NONE, LD_LB, LD_LBU, LD_LH, LD_LHU, LD_LW} loadKind;
    typedef enum logic [1:0] {ST_NONE, ST_SB, ST_SH, ST_SW} storeKind;
    typedef enum logic [1:0] {WB_LINK, WB_ALU, WB_LOAD, WB_CP0} wbSelect;

    // raised in fetch/decode/execute
    typedef struct packed {
        logic fetchAddrErr;
        logic reservedInstr;
        logic overflow;
        logic syscall;
        logic breakpoint;
    } earlyExc;

    typedef struct packed {
        logic [31:0] pc;
        instrWord    instr;
        logic [31:0] aluOut;       // also the data virtual address
        logic [31:0] storeData;    // rt value, store data or mtc0 data
        loadKind     load;
        storeKind    store;
        logic [4:0]  dst;
        logic        regWr;
        wbSelect     wbSel;
        logic        isMtc0;
        logic        isBranchOrJump;
        earlyExc     exc;
    } exeMemBundle;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  dst;
        logic        regWr;
        logic [31:0] result;
    } memWbBundle;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
    } apbRequest;

endpackage

// ==== memStage_defs.svh ====
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// cp0 register numbers, all at sel 0
`define CP0_REG_BADVADDR   5'd8
`define CP0_REG_COUNT      5'd9
`define CP0_REG_COMPARE    5'd11
`define CP0_REG_STATUS     5'd12
`define CP0_REG_CAUSE      5'd13
`define CP0_REG_EPC        5'd14

// exception entry points
`define EXC_VECTOR_BOOT    32'hBFC0_0380   // Status.BEV = 1
`define EXC_VECTOR_NORMAL  32'h8000_0180   // Status.BEV = 0

// unmapped segment bounds
`define KSEG0_BASE         32'h8000_0000
`define KSEG1_BASE         32'hA000_0000
`define KSEG_TOP           32'hC000_0000   // first address past kseg1

// BEV set, everything else clear
`define STATUS_RESET       32'h0040_0000

`endif
